// File: design/tetris_pkg.sv
package tetris_pkg;

	localparam int BOARD_ROWS = 24;
	localparam int BOARD_COLS = 24;
	localparam int ROW_W      = 5;
	localparam int SCORE_W    = 16;

	// bit c is column c
	typedef logic [BOARD_COLS-1:0] row_bits_t;

	typedef enum logic [2:0] {
		SHAPE_SQUARE,
		SHAPE_HBAR,
		SHAPE_VBAR,
		SHAPE_TEE,
		SHAPE_ELL
	} shape_e;

	typedef struct packed {
		shape_e           shape;
		logic [ROW_W-1:0] row;
		logic [ROW_W-1:0] col;
	} piece_t;

	typedef struct packed {
		logic landed;
		logic blocked_left;
		logic blocked_right;
		logic off_board;
	} piece_flags_t;

	// what one board row receives each cycle
	typedef struct packed {
		row_bits_t set;
		logic      lock;
		logic      shift;
		logic      wipe;
	} row_ctl_t;

	typedef enum logic [1:0] {
		OP_NOP,
		OP_LOCK,
		OP_WIPE
	} opcode_e;

	typedef enum logic [1:0] {
		CLR_IDLE,
		CLR_SCAN,
		CLR_SHIFT
	} clr_state_e;

	localparam logic [7:0] REG_PIECE    = 8'h00;
	localparam logic [7:0] REG_CMD      = 8'h04;
	localparam logic [7:0] REG_STATUS   = 8'h08;
	localparam logic [7:0] REG_SCORE    = 8'h0C;
	localparam logic [7:0] REG_ROW_BASE = 8'h40; // row r at base + 4r

endpackage

// File: design/piece_footprint.sv
`timescale 1ns/1ps

module piece_footprint import tetris_pkg::*; (
	input  piece_t       piece,
	input  row_bits_t    board [BOARD_ROWS],
	output piece_flags_t flags,
	output row_bits_t    set_mask [BOARD_ROWS]
);

	logic [1:0]        dr [4]; // row offsets, always downward
	logic signed [2:0] dc [4];
	logic              oob;
	logic              hit_floor;
	logic              hit_left;
	logic              hit_right;

	always_comb begin
		case (piece.shape)
			SHAPE_HBAR: begin
				dr = '{2'd0, 2'd0, 2'd0, 2'd0};
				dc = '{3'sd0, 3'sd1, 3'sd2, 3'sd3};
			end
			SHAPE_VBAR: begin
				dr = '{2'd0, 2'd1, 2'd2, 2'd3};
				dc = '{3'sd0, 3'sd0, 3'sd0, 3'sd0};
			end
			SHAPE_TEE: begin
				dr = '{2'd0, 2'd1, 2'd1, 2'd1};
				dc = '{3'sd0, -3'sd1, 3'sd0, 3'sd1};
			end
			SHAPE_ELL: begin
				dr = '{2'd0, 2'd1, 2'd2, 2'd2};
				dc = '{3'sd0, 3'sd0, 3'sd0, 3'sd1};
			end
			default: begin // square, also unused codes
				dr = '{2'd0, 2'd0, 2'd1, 2'd1};
				dc = '{3'sd0, 3'sd1, 3'sd0, 3'sd1};
			end
		endcase
	end

	// one-hot column per cell, or'd into its row
	always_comb begin
		int r;
		int c;
		oob = 1'b0;
		for (int i = 0; i < BOARD_ROWS; i++)
			set_mask[i] = '0;
		for (int k = 0; k < 4; k++) begin
			r = int'(piece.row) + int'(dr[k]);
			c = int'(piece.col) + int'(dc[k]);
			if (r >= BOARD_ROWS || c < 0 || c >= BOARD_COLS)
				oob = 1'b1;
			else
				set_mask[r][c] = 1'b1;
		end
	end

	// neighbour probes come straight from the shifted footprint
	always_comb begin
		int cells;
		hit_floor = |set_mask[BOARD_ROWS-1];
		hit_left  = 1'b0;
		hit_right = 1'b0;
		cells     = 0;
		for (int i = 0; i < BOARD_ROWS - 1; i++)
			hit_floor = hit_floor | (|(set_mask[i] & board[i+1]));
		for (int i = 0; i < BOARD_ROWS; i++) begin
			cells     = cells + $countones(set_mask[i]);
			hit_left  = hit_left | set_mask[i][0] | (|((set_mask[i] >> 1) & board[i]));
			hit_right = hit_right | set_mask[i][BOARD_COLS-1]
				| (|((set_mask[i] << 1) & board[i]));
		end

		flags.off_board     = oob;
		flags.landed        = hit_floor & ~oob;
		flags.blocked_left  = hit_left & ~oob;
		flags.blocked_right = hit_right & ~oob;

		// every shape covers four distinct cells
		assert (oob || cells == 4)
			else $error("piece footprint does not cover four cells");
	end

endmodule

// File: design/board_row.sv
`timescale 1ns/1ps

module board_row import tetris_pkg::*; (
	input  logic      ADDR,
	input  logic      rst_n,
	input  row_ctl_t  ctl,
	input  row_bits_t above,
	output row_bits_t bits,
	output logic      full
);

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			bits <= '0;
		end else if (ctl.wipe) begin
			bits <= '0;
		end else if (ctl.shift) begin
			bits <= above; // row above drops into this one
		end else if (ctl.lock) begin
			bits <= bits | ctl.set;
		end
	end

	assign full = &bits;

	// lock comes from the bus side, shift from the clear FSM
	a_lock_shift_excl: assert property (@(posedge ADDR) disable iff (!rst_n)
		!(ctl.lock && ctl.shift))
		else $error("lock and shift together on one row");

endmodule

// File: design/line_clear_ctrl.sv
`timescale 1ns/1ps

module line_clear_ctrl import tetris_pkg::*; (
	input  logic                  ADDR,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic                  wipe,
	input  logic [BOARD_ROWS-1:0] full,
	output logic [BOARD_ROWS-1:0] shift,
	output logic                  busy,
	output logic [SCORE_W-1:0]    score
);

	clr_state_e       state;
	logic [ROW_W-1:0] target;
	logic [ROW_W-1:0] lowest;

	// row 0 is the top, so the highest index wins
	always_comb begin
		lowest = '0;
		for (int r = 0; r < BOARD_ROWS; r++)
			if (full[r])
				lowest = ROW_W'(r);
	end

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			state <= CLR_IDLE;
			score <= '0;
		end else begin
			case (state)
				CLR_IDLE:  if (start) state <= CLR_SCAN;
				CLR_SCAN:  state <= (|full) ? CLR_SHIFT : CLR_IDLE;
				CLR_SHIFT: state <= CLR_SCAN;
				default:   state <= CLR_IDLE;
			endcase

			if (wipe)
				score <= '0;
			else if (state == CLR_SHIFT)
				score <= score + 1'b1; // one point per removed row
		end
	end

	always_ff @(posedge ADDR) begin
		if (state == CLR_SCAN)
			target <= lowest;
	end

	// target row and everything above it move down one
	always_comb begin
		for (int r = 0; r < BOARD_ROWS; r++)
			shift[r] = (state == CLR_SHIFT) && (ROW_W'(r) <= target);
	end

	assign busy = (state != CLR_IDLE);

	a_score_src: assert property (@(posedge ADDR) disable iff (!rst_n)
		(score != $past(score)) |-> ($past(state) == CLR_SHIFT || $past(wipe)))
		else $error("score moved outside a row shift or wipe");

endmodule

// File: design/apb_game_regs.sv
`timescale 1ns/1ps

module apb_game_regs import tetris_pkg::*; (
	input  logic               ADDR,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [7:0]         paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	input  piece_flags_t       flags,
	input  logic               busy,
	input  logic [SCORE_W-1:0] score,
	input  row_bits_t          board [BOARD_ROWS],
	output piece_t             piece,
	output logic               lock,
	output logic               wipe,
	output logic               clear_start
);

	logic             access;
	logic             cmd_wr;
	logic             lock_ok;
	logic             lock_pend;
	logic             wipe_pend;
	opcode_e          op;
	logic [7:0]       row_off;
	logic [ROW_W-1:0] row_idx;

	assign access  = psel & penable;
	assign op      = opcode_e'(pwdata[1:0]);
	assign lock_ok = flags.landed & ~flags.off_board;
	// first access cycle of a command write
	assign cmd_wr  = access & pwrite & (paddr == REG_CMD) & ~lock_pend & ~wipe_pend;

	assign lock        = cmd_wr & (op == OP_LOCK) & lock_ok;
	assign wipe        = cmd_wr & (op == OP_WIPE);
	assign clear_start = lock;
	assign pslverr     = cmd_wr & (op == OP_LOCK) & ~lock_ok;

	// lock waits out the clear FSM, wipe takes one wait state
	assign pready = access & (lock_pend ? ~busy : (wipe_pend | ~(lock | wipe)));

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			piece     <= '0;
			lock_pend <= 1'b0;
			wipe_pend <= 1'b0;
		end else begin
			if (access && pwrite && paddr == REG_PIECE) begin
				piece.shape <= shape_e'(pwdata[2:0]);
				piece.row   <= pwdata[12:8];
				piece.col   <= pwdata[20:16];
			end
			if (lock)
				lock_pend <= 1'b1;
			else if (lock_pend && pready)
				lock_pend <= 1'b0;
			wipe_pend <= wipe;
		end
	end

	assign row_off = paddr - REG_ROW_BASE;
	assign row_idx = row_off[6:2];

	always_comb begin
		prdata = '0;
		case (paddr)
			REG_PIECE:  prdata = {11'd0, piece.col, 3'd0, piece.row, 5'd0, piece.shape};
			REG_STATUS: prdata = {27'd0, busy, flags};
			REG_SCORE:  prdata = {{(32-SCORE_W){1'b0}}, score};
			default: begin
				if (paddr >= REG_ROW_BASE && row_off < 8'(BOARD_ROWS * 4))
					prdata = {8'd0, board[row_idx]};
			end
		endcase
	end

	a_lock_starts: assert property (@(posedge ADDR) disable iff (!rst_n)
		lock |=> busy)
		else $error("clear FSM did not start after an accepted lock");

endmodule

// File: design/tetris_core.sv
`timescale 1ns/1ps

module tetris_core import tetris_pkg::*; (
	input  logic        ADDR,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	piece_t                piece;
	piece_flags_t          flags;
	row_bits_t             board [BOARD_ROWS];
	row_bits_t             set_mask [BOARD_ROWS];
	logic [BOARD_ROWS-1:0] full;
	logic [BOARD_ROWS-1:0] shift;
	logic                  busy;
	logic                  lock;
	logic                  wipe;
	logic                  clear_start;
	logic [SCORE_W-1:0]    score;

	apb_game_regs u_regs (
		.ADDR(ADDR), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.flags(flags), .busy(busy), .score(score), .board(board),
		.piece(piece), .lock(lock), .wipe(wipe), .clear_start(clear_start)
	);

	piece_footprint u_foot (.piece(piece), .board(board), .flags(flags), .set_mask(set_mask));

	line_clear_ctrl u_clr (
		.ADDR(ADDR), .rst_n(rst_n), .start(clear_start), .wipe(wipe),
		.full(full), .shift(shift), .busy(busy), .score(score)
	);

	for (genvar r = 0; r < BOARD_ROWS; r++) begin : g_row
		row_ctl_t  ctl;
		row_bits_t above;

		assign ctl = '{set: set_mask[r], lock: lock, shift: shift[r], wipe: wipe};
		if (r == 0) begin : g_top
			assign above = '0; // top row fills with empty cells
		end else begin : g_inner
			assign above = board[r-1];
		end

		board_row u_row (
			.ADDR(ADDR), .rst_n(rst_n), .ctl(ctl), .above(above),
			.bits(board[r]), .full(full[r])
		);
	end

endmodule

// File: sim/tb_tetris.sv
`timescale 1ns/1ps

module tb_tetris import tetris_pkg::*; ();

	localparam int TEST_STEPS = 6;
	// (row, col) offsets per shape code: square, hbar, vbar, tee, ell
	localparam int DR [5][4] = '{'{0, 0, 1, 1}, '{0, 0, 0, 0}, '{0, 1, 2, 3}, '{0, 1, 1, 1},
		'{0, 1, 2, 2}};
	localparam int DC [5][4] = '{'{0, 1, 0, 1}, '{0, 1, 2, 3}, '{0, 0, 0, 0}, '{0, -1, 0, 1},
		'{0, 0, 0, 1}};

	logic        ADDR;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [23:0] model [24]; // board model, row 0 on top
	int          model_score;
	int          errors;
	int          checks;
	int          cur_shape;
	int          cur_row;
	int          cur_col;

	tetris_core dut0 (
		.ADDR(ADDR), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		ADDR = 1'b0;
		forever #20 ADDR = ~ADDR;
	end

	initial begin
		repeat (TEST_STEPS * 4000) @(posedge ADDR);
		$display("watchdog expired before the tests finished, %0d errors so far", errors);
		$display("TESTS FAILED");
		$finish;
	end

	function automatic logic [3:0] expected_flags(input int shape, input int row, input int col);
		int   r;
		int   c;
		logic land;
		logic left;
		logic right;
		land = 1'b0;
		left = 1'b0;
		right = 1'b0;
		for (int k = 0; k < 4; k++) begin
			r = row + DR[shape][k];
			c = col + DC[shape][k];
			if (r > 23 || c < 0 || c > 23)
				return 4'b0001; // off the board masks the rest
			if (r == 23 || model[r+1][c])
				land = 1'b1;
			if (c == 0 || model[r][c-1])
				left = 1'b1;
			if (c == 23 || model[r][c+1])
				right = 1'b1;
		end
		return {land, left, right, 1'b0};
	endfunction

	function automatic bit piece_fits(input int shape, input int row, input int col);
		int r;
		int c;
		for (int k = 0; k < 4; k++) begin
			r = row + DR[shape][k];
			c = col + DC[shape][k];
			if (r > 23 || c < 0 || c > 23)
				return 1'b0;
			if (model[r][c])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	function automatic int lowest_full();
		int found;
		found = -1;
		for (int r = 0; r < 24; r++)
			if (&model[r])
				found = r;
		return found;
	endfunction

	// writes the piece into the model and removes full rows, returns rows cleared
	function automatic int apply_lock(input int shape, input int row, input int col);
		int cleared;
		int full_row;
		cleared = 0;
		for (int k = 0; k < 4; k++)
			model[row + DR[shape][k]][col + DC[shape][k]] = 1'b1;
		full_row = lowest_full();
		while (full_row >= 0) begin
			for (int r = full_row; r > 0; r--)
				model[r] = model[r-1];
			model[0] = '0;
			model_score++;
			cleared++;
			full_row = lowest_full();
		end
		return cleared;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err, output int waits);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge ADDR);
		#2 penable = 1'b1;
		waits = 0;
		@(negedge ADDR); // mid-cycle, outputs settled
		while (!pready && waits < 200) begin
			waits++;
			@(negedge ADDR);
		end
		if (!pready) begin
			errors++;
			$display("transfer to address %h was never completed by the DUT", addr);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge ADDR);
		#2 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
			output logic err, output int waits);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, data, unused, err, waits);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		int waits;
		apb_xfer(1'b0, addr, 32'd0, data, err, waits);
		if (addr == REG_PIECE)
			check_val("piece read wait states", 32'(waits), 32'd0);
	endtask

	task automatic check_state();
		logic [31:0] rd;
		logic        err;
		for (int r = 0; r < 24; r++) begin
			apb_read(REG_ROW_BASE + 8'(4 * r), rd, err);
			check_val($sformatf("row[%0d]", r), rd, {8'd0, model[r]});
		end
		apb_read(REG_SCORE, rd, err);
		check_val("score", rd, 32'(model_score));
	endtask

	task automatic place(input int shape, input int row, input int col);
		logic [31:0] rd;
		logic        err;
		int          waits;
		cur_shape = shape;
		cur_row = row;
		cur_col = col;
		apb_write(REG_PIECE, 32'(shape) | (32'(row) << 8) | (32'(col) << 16), err, waits);
		check_val("piece write wait states", 32'(waits), 32'd0);
		apb_read(REG_STATUS, rd, err);
		check_val("status", rd, {28'd0, expected_flags(shape, row, col)});
	endtask

	task automatic lock_piece();
		logic [3:0] f;
		logic       err;
		int         waits;
		int         k;
		f = expected_flags(cur_shape, cur_row, cur_col);
		apb_write(REG_CMD, 32'(OP_LOCK), err, waits);
		if (f[3] && !f[0]) begin
			k = apply_lock(cur_shape, cur_row, cur_col);
			check_val("lock pslverr", 32'(err), 32'd0);
			check_val("lock wait states", 32'(waits), 32'(2 * k + 2)); // accept + busy
		end else begin
			check_val("lock pslverr", 32'(err), 32'd1);
			check_val("rejected lock wait states", 32'(waits), 32'd0);
		end
		check_state();
	endtask

	task automatic wipe_board();
		logic err;
		int   waits;
		apb_write(REG_CMD, 32'(OP_WIPE), err, waits);
		check_val("wipe pslverr", 32'(err), 32'd0);
		check_val("wipe wait states", 32'(waits), 32'd1);
		for (int r = 0; r < 24; r++)
			model[r] = '0;
		model_score = 0;
		check_state();
	endtask

	initial begin
		int unsigned seed_ret;
		int          shape;
		int          row;
		int          col;
		int          lo;
		int          hi;
		logic [3:0]  f;
		logic [31:0] rd;
		logic        err;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'd0;
		pwdata = 32'd0;
		seed_ret = $urandom(32'he12dca9b);
		for (int r = 0; r < 24; r++)
			model[r] = '0;
		model_score = 0;
		errors = 0;
		checks = 0;
		repeat (10) @(posedge ADDR);
		#2 rst_n = 1'b1;

		apb_read(REG_PIECE, rd, err);
		check_val("piece", rd, 32'd0);
		apb_read(REG_STATUS, rd, err); // square at 0,0 touches the left wall
		check_val("status", rd, {28'd0, expected_flags(0, 0, 0)});
		check_state();

		place(0, 22, 0);
		lock_piece();

		place(2, 5, 10); // floating vbar
		lock_piece();
		place(1, 0, 23); // hbar past the right edge
		lock_piece();

		wipe_board();
		for (int i = 0; i < 5; i++) begin
			place(1, 23, 4 * i);
			lock_piece();
		end
		place(3, 21, 1); // tee resting on the bars
		lock_piece();
		place(1, 23, 20);
		lock_piece();

		wipe_board();
		for (int i = 0; i < 12; i++) begin
			place(0, 22, 2 * i);
			lock_piece();
		end

		for (int n = 0; n < 24; n++) begin
			shape = $urandom % 5;
			lo = (shape == 3) ? 1 : 0;
			hi = 23 - DC[shape][3];
			col = lo + $urandom % (hi - lo + 1);
			if (!piece_fits(shape, 0, col)) begin
				wipe_board(); // stack reached the top
				continue;
			end
			row = 0;
			f = expected_flags(shape, row, col);
			while (!f[3]) begin
				row++;
				f = expected_flags(shape, row, col);
			end
			place(shape, row, col);
			lock_piece();
		end
		wipe_board();

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: sources.f
design/tetris_pkg.sv
design/piece_footprint.sv
design/board_row.sv
design/line_clear_ctrl.sv
design/apb_game_regs.sv
design/tetris_core.sv
sim/tb_tetris.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_tetris \
	-o tb_tetris \
	&& ./obj_dir/tb_tetris | tee /dev/stderr | grep -q "TESTS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
